//--- ialu_top.f
ialu_pkg.sv
ialu_int_unit.sv
ialu_mul_unit.sv
ialu_res_mux.sv
ialu_top.sv
ialu_assert.sv
tb_ialu_top.sv

//--- Makefile
# Verilator build and run for the integer ALU

VERILATOR ?= verilator
TOP       ?= tb_ialu_top
FILELIST  ?= ialu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_ialu_top.sv
// Integer ALU directed testbench
`timescale 1ns/1ps

module tb_ialu_top;

    import ialu_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      cmd_vd;
    ialu_cmd_e cmd;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     res;
    logic      cmp;
    logic      rdy;
    integer    seed;
    int        err_cnt;
    int        test_cnt;
    int        test_err;                        // Error count at test start

    ialu_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_vd_i (cmd_vd),
        .cmd_i    (cmd),
        .op1_i    (op1),
        .op2_i    (op2),
        .res_o    (res),
        .cmp_o    (cmp),
        .rdy_o    (rdy)
    );

    always #4 clk = ~clk;                       // 8 ns period

    // --------------------
    // Compare and drive
    // --------------------
    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    // Drive on the falling edge, then let the logic settle
    task automatic apply(input ialu_cmd_e c, input xlen_t a, input xlen_t b, input logic vd);
        @(negedge clk);
        cmd_vd = vd;
        cmd    = c;
        op1    = a;
        op2    = b;
        #1;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_err) begin
            $display("%s done, ok", name);
        end else begin
            $display("%s done, %0d errors", name, err_cnt - test_err);
        end
        test_err = err_cnt;
    endtask

    // --------------------
    // Reference models
    // --------------------
    function automatic xlen_t alu_ref(input ialu_cmd_e c, input xlen_t a, input xlen_t b);
        case (c)
            ADD     : return a + b;
            SUB     : return a - b;
            AND     : return a & b;
            OR      : return a | b;
            XOR     : return a ^ b;
            SLL     : return a << b[4:0];
            SRL     : return a >> b[4:0];
            default : return (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0);
        endcase
    endfunction

    function automatic logic cmp_ref(input ialu_cmd_e c, input xlen_t a, input xlen_t b);
        case (c)
            SUB_LT  : return $signed(a) < $signed(b);
            SUB_LTU : return a < b;
            SUB_EQ  : return a == b;
            SUB_NE  : return a != b;
            SUB_GE  : return $signed(a) >= $signed(b);
            default : return a >= b;            // GEU
        endcase
    endfunction

    function automatic xlen_t mul_ref(input ialu_cmd_e c, input xlen_t a, input xlen_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        ea   = {{32{a[31] & (c != MULHU)}}, a};   // Only MULHU takes op1 unsigned
        eb   = {{32{b[31] & (c == MULH)}}, b};    // Low half same either way
        prod = ea * eb;                           // Wraps mod 2^64
        return (c == MUL) ? prod[31:0] : prod[63:32];
    endfunction

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset();
        apply(NONE, '0, '0, 1'b0);
        check_bit("reset rdy", 1'b1, rdy);
        check_bit("reset cmp", 1'b0, cmp);
        check_word("reset res", '0, res);
        finish_test("reset");
    endtask

    task automatic test_int(input string tname, input ialu_cmd_e c, input xlen_t a,
                            input xlen_t b);
        string name;
        name = {tname, " ", c.name()};
        apply(c, a, b, 1'b0);
        if (c inside {SUB_LT, SUB_LTU, SUB_EQ, SUB_NE, SUB_GE, SUB_GEU}) begin
            check_bit(name, cmp_ref(c, a, b), cmp);
            check_word(name, {31'b0, cmp_ref(c, a, b)}, res);
        end else begin
            check_word(name, alu_ref(c, a, b), res);
        end
        check_bit({name, " rdy"}, 1'b1, rdy);     // Same cycle
    endtask

    task automatic run_mul(input ialu_cmd_e c, input xlen_t a, input xlen_t b, input int exp_cyc);
        int    cyc;
        string name;
        name = {"mul ", c.name()};
        apply(c, a, b, 1'b1);
        cyc = 0;
        while (!rdy && cyc < 64) begin
            @(negedge clk);
            #1;
            cyc++;
        end
        if (!rdy) begin
            $display("%s never raised rdy_o within 64 cycles", name);
            err_cnt++;
        end else begin
            check_word(name, mul_ref(c, a, b), res);
            if (cyc != exp_cyc) begin
                $display("ERR %s ready cycle expected %0d actual %0d", name, exp_cyc, cyc);
                err_cnt++;
            end
        end
        apply(NONE, '0, '0, 1'b0);             // Release after the ready edge
        check_bit({name, " rdy after drop"}, 1'b1, rdy);
    endtask

    // Multiply dropped mid-iteration, the next one starts from the first step
    task automatic abort_mul(input xlen_t a, input xlen_t b);
        apply(MULHU, a, b, 1'b1);
        repeat (4) @(negedge clk);
        #1;
        check_bit("abort busy rdy", 1'b0, rdy);  // Cycle 4, still iterating
        apply(NONE, '0, '0, 1'b0);               // Valid dropped while in ITER
        run_mul(MULHU, a, b, 31);
    endtask

    initial begin
        xlen_t     bnd [3]  = '{32'h0, 32'h7fffffff, 32'h80000000};
        xlen_t     ca [6]   = '{32'h5, 32'h7fffffff, 32'h80000000, 32'h80000000,
                                32'hffffffff, 32'h0};
        xlen_t     cb [6]   = '{32'h5, 32'h80000000, 32'h7fffffff, 32'h1, 32'h1, 32'hffffffff};
        xlen_t     ma [5]   = '{32'h80000000, 32'hffffffff, 32'h7fffffff, 32'h1, 32'h80000000};
        xlen_t     mb [5]   = '{32'h80000000, 32'hffffffff, 32'h80000000, 32'hffffffff,
                                32'hffffffff};
        ialu_cmd_e arith[5] = '{ADD, SUB, AND, OR, XOR};
        ialu_cmd_e cmps[6]  = '{SUB_LT, SUB_LTU, SUB_EQ, SUB_NE, SUB_GE, SUB_GEU};
        ialu_cmd_e shfts[3] = '{SLL, SRL, SRA};
        ialu_cmd_e muls[4]  = '{MUL, MULH, MULHSU, MULHU};
        xlen_t     a;
        xlen_t     b;
        clk      = 1'b0;
        rst_n    = 1'b0;
        cmd_vd   = 1'b0;
        cmd      = NONE;
        op1      = '0;
        op2      = '0;
        seed     = 32'h2f1a;
        err_cnt  = 0;
        test_cnt = 0;
        test_err = 0;
        repeat (3) @(posedge clk);              // Reset for 3 cycles
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();

        for (int i = 0; i < 15; i++) begin      // Boundary grid, then random
            a = (i < 9) ? bnd[i / 3] : xlen_t'($random(seed));
            b = (i < 9) ? bnd[i % 3] : xlen_t'($random(seed));
            foreach (arith[k]) test_int("arith", arith[k], a, b);
        end
        finish_test("arith");

        for (int i = 0; i < 10; i++) begin
            a = (i < 6) ? ca[i] : xlen_t'($random(seed));
            b = (i < 6) ? cb[i] : xlen_t'($random(seed));
            foreach (cmps[k]) test_int("compare", cmps[k], a, b);
        end
        finish_test("compare");

        for (int i = 0; i < 9; i++) begin
            a = (i % 3 == 0) ? 32'h80000000 : xlen_t'($random(seed));
            b = xlen_t'($random(seed));         // Upper bits must be ignored
            if (i < 3) b[4:0] = 5'd0;
            else if (i < 6) b[4:0] = 5'd31;
            foreach (shfts[k]) test_int("shift", shfts[k], a, b);
        end
        finish_test("shift");

        for (int i = 0; i < 8; i++) begin
            a = (i < 5) ? ma[i] : (xlen_t'($random(seed)) | 32'h1);  // Kept non-zero
            b = (i < 5) ? mb[i] : (xlen_t'($random(seed)) | 32'h2);
            foreach (muls[k]) run_mul(muls[k], a, b, 31);
        end
        finish_test("multiply");

        abort_mul(32'h89abcdef, 32'h13579bdf);
        finish_test("abort");

        foreach (muls[k]) begin
            run_mul(muls[k], 32'h0, 32'h1234abcd, 0);
            run_mul(muls[k], 32'h80000000, 32'h0, 0);
            run_mul(muls[k], 32'h0, 32'h0, 0);
        end
        finish_test("zero operand");

        $display("Tests %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- ialu_assert.sv
// Multiplier FSM assertions
`timescale 1ns/1ps

module ialu_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    cmd_vd_i,
    input ialu_pkg::ialu_cmd_e     cmd_i,
    input ialu_pkg::xlen_t         op1_i,
    input ialu_pkg::xlen_t         op2_i,
    input ialu_pkg::ialu_mul_fsm_e fsm_i,       // Multiplier state
    input ialu_pkg::xlen_t         cnt_i        // One-hot iteration counter
);

    import ialu_pkg::*;

    logic is_mul;
    logic ops_nz;                               // Both operands non-zero

    assign is_mul = cmd_i inside {MUL, MULH, MULHSU, MULHU};
    assign ops_nz = (op1_i != '0) && (op2_i != '0);

    // --------------------
    // FSM sequencing
    // --------------------
    a_start : assert property (@(posedge clk) disable iff (!rst_n)
        (fsm_i == IDLE) && cmd_vd_i && is_mul && ops_nz |=> (fsm_i == ITER))
        else $error("Multiply start did not enter ITER");

    // Counter not yet at bit 0, keep iterating
    a_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (fsm_i == ITER) && cmd_vd_i && !cnt_i[0] |=> (fsm_i == ITER))
        else $error("ITER left before the last step");

    a_abort : assert property (@(posedge clk) disable iff (!rst_n)
        (fsm_i == ITER) && !cmd_vd_i |=> (fsm_i == IDLE))   // Dropped command
        else $error("ITER held without a valid command");

endmodule

bind ialu_mul_unit ialu_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vd_i (cmd_vd_i),
    .cmd_i    (cmd_i),
    .op1_i    (op1_i),
    .op2_i    (op2_i),
    .fsm_i    (fsm_ff),
    .cnt_i    (cnt_ff)
);

//--- ialu_top.sv
// Integer ALU top level
`timescale 1ns/1ps

module ialu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_vd_i,       // Multiply command valid
    input  ialu_pkg::ialu_cmd_e cmd_i,
    input  ialu_pkg::xlen_t     op1_i,
    input  ialu_pkg::xlen_t     op2_i,
    output ialu_pkg::xlen_t     res_o,
    output logic                cmp_o,
    output logic                rdy_o
);

    import ialu_pkg::*;

    ialu_int_res_t int_res;                     // Adder, logic, shift
    ialu_mul_res_t mul_res;                     // Product and ready

    // --------------------
    // Units
    // --------------------
    ialu_int_unit u_int (
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .int_res_o (int_res)
    );

    ialu_mul_unit u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vd_i  (cmd_vd_i),
        .cmd_i     (cmd_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .mul_res_o (mul_res)
    );

    // Final select
    ialu_res_mux u_mux (
        .cmd_i     (cmd_i),
        .int_res_i (int_res),
        .mul_res_i (mul_res),
        .res_o     (res_o),
        .cmp_o     (cmp_o),
        .rdy_o     (rdy_o)
    );

endmodule

//--- ialu_res_mux.sv
// Integer ALU result select
`timescale 1ns/1ps

module ialu_res_mux (
    input  ialu_pkg::ialu_cmd_e     cmd_i,
    input  ialu_pkg::ialu_int_res_t int_res_i,  // Single-cycle unit
    input  ialu_pkg::ialu_mul_res_t mul_res_i,  // Multiplier
    output ialu_pkg::xlen_t         res_o,
    output logic                    cmp_o,      // Compare bit
    output logic                    rdy_o       // Result ready
);

    import ialu_pkg::*;

    ialu_flags_t flags;
    logic        lt;                            // Signed less than
    logic        is_cmp;

    assign flags = int_res_i.flags;
    assign lt    = flags.s ^ flags.o;

    always_comb begin
        is_cmp = 1'b1;
        case (cmd_i)
            SUB_LT  : cmp_o = lt;
            SUB_LTU : cmp_o = flags.c;
            SUB_EQ  : cmp_o = flags.z;
            SUB_NE  : cmp_o = ~flags.z;
            SUB_GE  : cmp_o = ~lt;
            SUB_GEU : cmp_o = ~flags.c;
            default : begin
                cmp_o  = 1'b0;
                is_cmp = 1'b0;
            end
        endcase

        // Word and ready
        res_o = int_res_i.word;
        rdy_o = 1'b1;
        if (cmd_i == NONE) begin
            res_o = '0;
        end else if (is_cmp) begin
            res_o = XLEN'(cmp_o);               // Zero-extended compare bit
        end else if (mul_res_i.active) begin
            res_o = mul_res_i.word;
            rdy_o = mul_res_i.rdy;
        end
    end

endmodule

//--- ialu_mul_unit.sv
// Iterative radix-2 multiplier
`timescale 1ns/1ps

module ialu_mul_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_vd_i,   // Multiply command valid
    input  ialu_pkg::ialu_cmd_e     cmd_i,
    input  ialu_pkg::xlen_t         op1_i,      // Multiplicand
    input  ialu_pkg::xlen_t         op2_i,      // Multiplier
    output ialu_pkg::ialu_mul_res_t mul_res_o
);

    import ialu_pkg::*;

    logic                        cmd_mul;       // Any of the four multiplies
    logic                        cmd_hi;        // High half requested
    logic                        op1_sgn;       // op1 taken as signed
    logic                        op2_sgn;       // op2 taken as signed
    logic                        ops_non_zero;
    logic                        iter_req;      // Start iterating
    logic                        iter_rdy;      // Last step
    logic                        res_rdy;
    logic                        upd;           // Registers and counter advance
    ialu_mul_fsm_e               fsm_ff;
    ialu_mul_fsm_e               fsm_next;
    logic                        fsm_idle;
    xlen_t                       cnt_ff;        // One-hot iteration counter
    xlen_t                       cnt_next;
    logic signed [MUL_SUM_W-1:0] mul_op1;       // Extended multiplicand
    logic                        mul_bit;       // Current multiplier bit
    logic                        mul_neg;       // Bit carries negative weight
    logic signed [MUL_SUM_W-1:0] part_prod;
    logic signed [MUL_SUM_W-1:0] acc;           // Extended high register
    logic signed [MUL_SUM_W-1:0] sum;
    xlen_t                       lo_src;        // Multiplier bits still to use
    xlen_t                       res_hi;
    xlen_t                       res_lo;
    xlen_t                       hi_ff;
    xlen_t                       lo_ff;

    // --------------------
    // Command decode
    // --------------------
    assign cmd_mul = (cmd_i == MUL) | (cmd_i == MULH) | (cmd_i == MULHSU) | (cmd_i == MULHU);
    assign cmd_hi  = cmd_mul & (cmd_i != MUL);
    assign op1_sgn = (cmd_i == MUL) | (cmd_i == MULH) | (cmd_i == MULHSU);
    assign op2_sgn = (cmd_i == MUL) | (cmd_i == MULH);  // Low half same either way

    assign ops_non_zero = |op1_i & |op2_i;
    assign fsm_idle     = (fsm_ff == IDLE);
    assign iter_req     = cmd_mul & ops_non_zero & fsm_idle;
    assign iter_rdy     = cnt_ff[0];
    assign res_rdy      = fsm_idle ? ~iter_req : (~cmd_mul | iter_rdy);
    assign upd          = cmd_vd_i & ~res_rdy;

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_ff <= IDLE;
        end else begin
            fsm_ff <= fsm_next;
        end
    end

    always_comb begin
        fsm_next = IDLE;                        // Dropped command aborts
        if (cmd_vd_i) begin
            case (fsm_ff)
                IDLE : fsm_next = iter_req ? ITER : IDLE;
                ITER : fsm_next = iter_rdy ? IDLE : ITER;
            endcase
        end
    end

    // Counter, loaded while idle
    assign cnt_next = fsm_idle ? MUL_CNT_INIT : cnt_ff >> 1;

    always_ff @(posedge clk) begin
        if (upd) begin
            cnt_ff <= cnt_next;
        end
    end

    // --------------------
    // Datapath
    // --------------------
    assign mul_op1 = $signed({op1_sgn & op1_i[XLEN-1], op1_i});
    assign lo_src  = fsm_idle ? op2_i : lo_ff;
    assign mul_bit = lo_src[0];
    assign mul_neg = ~fsm_idle & iter_rdy & op2_sgn & mul_bit;  // MSB of signed op2

    always_comb begin
        if (!mul_bit) begin
            part_prod = '0;
        end else if (mul_neg) begin
            part_prod = -mul_op1;
        end else begin
            part_prod = mul_op1;
        end
        acc = fsm_idle ? '0 : $signed({op1_sgn & hi_ff[XLEN-1], hi_ff});
        sum = acc + part_prod;
        {res_hi, res_lo} = {sum, lo_src[XLEN-1:1]};  // Sum low bit shifts into lo
    end

    always_ff @(posedge clk) begin
        if (upd) begin
            hi_ff <= res_hi;
            lo_ff <= res_lo;
        end
    end

    // Output, zero while idle covers the zero-operand shortcut
    assign mul_res_o.active = cmd_mul;
    assign mul_res_o.rdy    = res_rdy;
    assign mul_res_o.word   = fsm_idle ? '0 : (cmd_hi ? res_hi : res_lo);

endmodule

//--- ialu_int_unit.sv
// Integer ALU single-cycle unit
`timescale 1ns/1ps

module ialu_int_unit (
    input  ialu_pkg::ialu_cmd_e     cmd_i,      // ALU command
    input  ialu_pkg::xlen_t         op1_i,      // First operand
    input  ialu_pkg::xlen_t         op2_i,      // Second operand
    output ialu_pkg::ialu_int_res_t int_res_o   // Word and flags
);

    import ialu_pkg::*;

    logic [XLEN:0]      sum;                    // Carry-out on top bit
    logic               pos_ovflw;              // Positive minus negative went negative
    logic               neg_ovflw;              // Negative minus positive went positive
    ialu_flags_t        flags;
    logic [SHAMT_W-1:0] shamt;                  // Shift amount
    xlen_t              logic_res;
    xlen_t              shft_res;
    xlen_t              word;

    // --------------------
    // Main adder
    // --------------------
    // Subtracts for everything but ADD, so the flags serve the compares
    always_comb begin
        if (cmd_i == ADD) begin
            sum = {1'b0, op1_i} + {1'b0, op2_i};
        end else begin
            sum = {1'b0, op1_i} - {1'b0, op2_i};
        end

        pos_ovflw = ~op1_i[XLEN-1] &  op2_i[XLEN-1] &  sum[XLEN-1];
        neg_ovflw =  op1_i[XLEN-1] & ~op2_i[XLEN-1] & ~sum[XLEN-1];

        flags.c = sum[XLEN];                    // Borrow means op1 < op2 unsigned
        flags.z = ~|sum[XLEN-1:0];
        flags.s = sum[XLEN-1];
        flags.o = pos_ovflw | neg_ovflw;
    end

    // --------------------
    // Logic and shifts
    // --------------------
    assign shamt = op2_i[SHAMT_W-1:0];          // Upper op2 bits ignored

    always_comb begin
        case (cmd_i)
            OR      : logic_res = op1_i | op2_i;
            XOR     : logic_res = op1_i ^ op2_i;
            default : logic_res = op1_i & op2_i;
        endcase
    end

    always_comb begin
        case (cmd_i)
            SRL     : shft_res = op1_i >> shamt;
            SRA     : shft_res = $signed(op1_i) >>> shamt;  // Sign bit copied in
            default : shft_res = op1_i << shamt;
        endcase
    end

    // Word select
    always_comb begin
        case (cmd_i)
            AND, OR, XOR  : word = logic_res;
            SLL, SRL, SRA : word = shft_res;
            default       : word = sum[XLEN-1:0];
        endcase
    end

    assign int_res_o.word  = word;
    assign int_res_o.flags = flags;

endmodule

//--- ialu_pkg.sv
// Integer ALU shared definitions
package ialu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN    = 32;                // Data word width
    localparam int SHAMT_W = 5;                 // Shift amount, low bits of op2

    typedef logic [XLEN-1:0] xlen_t;            // Operand or result word

    // --------------------
    // Commands
    // --------------------
    typedef enum logic [4:0] {
        NONE,                                   // No operation, result forced to 0
        AND,
        OR,
        XOR,
        ADD,
        SUB,
        SUB_LT,                                 // Signed less than
        SUB_LTU,                                // Unsigned less than
        SUB_EQ,
        SUB_NE,
        SUB_GE,                                 // Signed greater or equal
        SUB_GEU,                                // Unsigned greater or equal
        SLL,
        SRL,
        SRA,
        MUL,                                    // Low half
        MULH,                                   // High half, signed x signed
        MULHSU,                                 // High half, signed x unsigned
        MULHU                                   // High half, unsigned x unsigned
    } ialu_cmd_e;

    // --------------------
    // Result structs
    // --------------------
    typedef struct packed {
        logic z;                                // Zero
        logic s;                                // Sign
        logic o;                                // Overflow
        logic c;                                // Carry, borrow on subtract
    } ialu_flags_t;

    typedef struct packed {
        xlen_t       word;                      // Sum, logic or shift result
        ialu_flags_t flags;                     // Main adder flags
    } ialu_int_res_t;

    typedef struct packed {
        logic  active;                          // Command is a multiply
        logic  rdy;                             // Product ready this cycle
        xlen_t word;                            // Selected product half
    } ialu_mul_res_t;

    // --------------------
    // Multiplier
    // --------------------
    localparam int    MUL_SUM_W    = XLEN + 1;                  // Partial sum, one extra bit
    localparam xlen_t MUL_CNT_INIT = xlen_t'(1) << (XLEN - 2);  // One-hot, bit 30

    typedef enum logic {
        IDLE,                                   // Waiting, first step done here
        ITER                                    // Remaining 31 steps
    } ialu_mul_fsm_e;

endpackage
